// ==== mac_fixed_pkg.sv ====
// Q8.8 fixed-point sample and product types, fraction width
`default_nettype none

package mac_fixed_pkg;

    //////////////////////////////////////////////////////////////////////
    // number format
    //////////////////////////////////////////////////////////////////////

    // Q8.8 with 8 integer and 8 fraction bits
    localparam int FRAC_BITS    = 8;
    localparam int SAMPLE_BITS  = 16;
    localparam int PRODUCT_BITS = 2 * SAMPLE_BITS;

    // weights, activations, bias, partial sums and result
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // full product before rescale
    typedef logic signed [PRODUCT_BITS-1:0] product_t;

endpackage

`default_nettype wire

// ==== mac_geometry_pkg.sv ====
// array dimensions and lane-vector types built from them
`default_nettype none

package mac_geometry_pkg;

    import mac_fixed_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // array shape
    //////////////////////////////////////////////////////////////////////

    localparam int LANES_PER_PE      = 4;
    localparam int PES_PER_CHANNEL   = 2;
    localparam int NUM_CHANNELS      = 2;
    localparam int LANES_PER_CHANNEL = LANES_PER_PE * PES_PER_CHANNEL;
    localparam int TOTAL_LANES       = LANES_PER_CHANNEL * NUM_CHANNELS;

    // lane 0 in the lowest 16 bits of every vector
    typedef sample_t [LANES_PER_PE-1:0]      pe_vec_t;
    typedef sample_t [LANES_PER_CHANNEL-1:0] channel_vec_t;
    typedef sample_t [TOTAL_LANES-1:0]       array_vec_t;

endpackage

`default_nettype wire

// ==== mac_pe.sv ====
// processing element with lane multiply, Q8.8 rescale and registered lane sum
`timescale 1ns/1ps
`default_nettype none

module mac_pe
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance,
    input  pe_vec_t weights,
    input  pe_vec_t activations,
    output sample_t pe_sum
);

    product_t lane_prod   [LANES_PER_PE];
    sample_t  lane_scaled [LANES_PER_PE];
    sample_t  lane_total;

    //////////////////////////////////////////////////////////////////////
    // per-lane multiply
    //////////////////////////////////////////////////////////////////////

    // shift back to Q8.8 and keep the low 16 bits
    always_comb begin
        for (int i = 0; i < LANES_PER_PE; i++) begin
            lane_prod[i]   = product_t'($signed(weights[i])) *
                             product_t'($signed(activations[i]));
            lane_scaled[i] = sample_t'(lane_prod[i] >>> FRAC_BITS);
        end
    end

    // folded wrapping adder tree
    always_comb begin
        lane_total = '0;
        for (int i = 0; i < LANES_PER_PE; i++) begin
            lane_total = lane_total + lane_scaled[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1 register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pe_sum <= '0;
        end else if (advance) begin
            pe_sum <= lane_total;
        end
    end

endmodule

`default_nettype wire

// ==== mac_channel.sv ====
// channel of processing elements with registered channel sum
`timescale 1ns/1ps
`default_nettype none

module mac_channel
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         advance,
    input  channel_vec_t weights,
    input  channel_vec_t activations,
    output sample_t      channel_sum
);

    sample_t pe_sums [PES_PER_CHANNEL];
    sample_t pe_total;

    //////////////////////////////////////////////////////////////////////
    // processing elements
    //////////////////////////////////////////////////////////////////////

    // element g owns lanes g*4 .. g*4+3 of this channel
    for (genvar g = 0; g < PES_PER_CHANNEL; g++) begin : g_pe
        mac_pe i_pe (
            .clk         (clk),
            .rst_n       (rst_n),
            .advance     (advance),
            .weights     (weights[g*LANES_PER_PE +: LANES_PER_PE]),
            .activations (activations[g*LANES_PER_PE +: LANES_PER_PE]),
            .pe_sum      (pe_sums[g])
        );
    end

    always_comb begin
        pe_total = '0;
        for (int p = 0; p < PES_PER_CHANNEL; p++) begin
            pe_total = pe_total + pe_sums[p];
        end
    end

    // stage 2 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            channel_sum <= '0;
        end else if (advance) begin
            channel_sum <= pe_total;
        end
    end

endmodule

`default_nettype wire

// ==== dot_accumulator.sv ====
// cross-channel sum, valid tracking, beat accumulation, bias add, output handshake
`timescale 1ns/1ps
`default_nettype none

module dot_accumulator
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t channel_sums [NUM_CHANNELS],
    input  logic    in_valid,
    input  logic    in_last,
    input  sample_t bias,
    input  logic    out_ready,
    output logic    advance,
    output sample_t dot_product,
    output logic    out_valid
);

    // index 0 lines up with the element sums, 2 with beat_sum
    logic [2:0] stage_valid;
    logic [2:0] stage_last;
    sample_t    stage_bias [3];

    sample_t    cross_sum;
    sample_t    beat_sum;
    sample_t    running_total;
    logic       beat_done;
    logic       beat_closes;

    //////////////////////////////////////////////////////////////////////
    // back-pressure
    //////////////////////////////////////////////////////////////////////

    // whole array stalls only while a result waits unaccepted
    assign advance = !(out_valid && !out_ready);

    assign beat_done   = advance && stage_valid[2];
    assign beat_closes = beat_done && stage_last[2];

    //////////////////////////////////////////////////////////////////////
    // stage 3 and sideband shift
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cross_sum = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            cross_sum = cross_sum + channel_sums[c];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[1:0], in_valid};
        end
    end

    // last and bias ride along with the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            stage_last    <= {stage_last[1:0], in_last};
            stage_bias[0] <= bias;
            stage_bias[1] <= stage_bias[0];
            stage_bias[2] <= stage_bias[1];
            beat_sum      <= cross_sum;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulation and result
    //////////////////////////////////////////////////////////////////////

    // a last beat clears the total for the next dot product
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running_total <= '0;
            out_valid     <= 1'b0;
        end else begin
            if (advance) begin
                out_valid <= beat_closes;
            end
            if (beat_closes) begin
                running_total <= '0;
            end else if (beat_done) begin
                running_total <= running_total + beat_sum;
            end
        end
    end

    // held while the consumer stalls, replaced on the accepting edge
    always_ff @(posedge clk) begin
        if (beat_closes) begin
            dot_product <= running_total + beat_sum + stage_bias[2];
        end
    end

endmodule

`default_nettype wire

// ==== mac_array.sv ====
// top level with lane bus slicing, channel instances and accumulator
`timescale 1ns/1ps
`default_nettype none

module mac_array
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  array_vec_t weights,
    input  array_vec_t activations,
    input  logic       in_last,
    input  sample_t    bias,
    output logic       out_valid,
    input  logic       out_ready,
    output sample_t    dot_product
);

    logic    advance;
    sample_t channel_sums [NUM_CHANNELS];

    // a beat is taken whenever the pipeline moves
    assign in_ready = advance;

    //////////////////////////////////////////////////////////////////////
    // channels
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
        mac_channel i_channel (
            .clk         (clk),
            .rst_n       (rst_n),
            .advance     (advance),
            .weights     (weights[g*LANES_PER_CHANNEL +: LANES_PER_CHANNEL]),
            .activations (activations[g*LANES_PER_CHANNEL +: LANES_PER_CHANNEL]),
            .channel_sum (channel_sums[g])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // reduction and output
    //////////////////////////////////////////////////////////////////////

    dot_accumulator i_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .channel_sums (channel_sums),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .bias         (bias),
        .out_ready    (out_ready),
        .advance      (advance),
        .dot_product  (dot_product),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

// ==== mac_checker.sv ====
// reference model, result comparison, hold, latency and reset checks
`timescale 1ns/1ps
`default_nettype none

module mac_checker
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       in_ready,
    input  array_vec_t weights,
    input  array_vec_t activations,
    input  logic       in_last,
    input  sample_t    bias,
    input  logic       out_valid,
    input  logic       out_ready,
    input  sample_t    dot_product,
    output int         value_errors,
    output int         other_errors,
    output int         results_seen,
    output int         pending
);

    localparam int LATENCY = 3;

    sample_t expected_q [$];
    int      last_edge_q [$];
    sample_t running;
    int      edge_index;
    int      last_stall;
    logic    beat_seen;
    logic    prev_valid;
    logic    prev_ready;
    sample_t prev_data;

    // Q8.8 product keeps bits 23..8 and every sum wraps at 16 bits
    function automatic sample_t beat_sum(input array_vec_t w, input array_vec_t a);
        product_t full;
        sample_t  total;
        total = '0;
        for (int i = 0; i < TOTAL_LANES; i++) begin
            full  = product_t'(w[i]) * product_t'(a[i]);
            total = total + sample_t'(full[FRAC_BITS +: 16]);
        end
        return total;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // sampling on every rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : watch
        sample_t beat;
        sample_t expected;
        int      stamp;
        if (!rst_n) begin
            running    = '0;
            edge_index = 0;
            last_stall = -1;
            beat_seen  = 1'b0;
            prev_valid = 1'b0;
            prev_ready = 1'b1;
            prev_data  = '0;
            expected_q.delete();
            last_edge_q.delete();
        end else begin
            edge_index = edge_index + 1;
            if (!beat_seen && (out_valid || !in_ready)) begin
                $display("DUT not idle after reset at %0t: out_valid=%0b in_ready=%0b",
                         $time, out_valid, in_ready);
                other_errors++;
            end
            // held result must not move
            if (prev_valid && !prev_ready) begin
                if (!out_valid) begin
                    $display("out_valid dropped at %0t without a handshake", $time);
                    other_errors++;
                end else if (dot_product !== prev_data) begin
                    $display("CHECK FAILED at %0t: held dot_product changed from %0d to %0d",
                             $time, prev_data, dot_product);
                    value_errors++;
                end
            end
            // latency of a fresh result counted only when nothing stalled
            if (out_valid && (!prev_valid || prev_ready)) begin
                if (last_edge_q.size() == 0) begin
                    $display("result presented at %0t with no last beat sent", $time);
                    other_errors++;
                end else begin
                    stamp = last_edge_q.pop_front();
                    if (last_stall <= stamp && edge_index - 1 - stamp != LATENCY) begin
                        $display("latency wrong at %0t: %0d cycles instead of %0d",
                                 $time, edge_index - 1 - stamp, LATENCY);
                        other_errors++;
                    end
                end
            end
            if (out_valid && !out_ready) begin
                last_stall = edge_index;
            end
            if (out_valid && out_ready) begin
                results_seen++;
                if (expected_q.size() == 0) begin
                    $display("output handshake at %0t with no expected result", $time);
                    other_errors++;
                end else begin
                    expected = expected_q.pop_front();
                    if (dot_product !== expected) begin
                        $display("CHECK FAILED at %0t: expected %0d, received %0d",
                                 $time, expected, dot_product);
                        value_errors++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                beat_seen = 1'b1;
                beat      = beat_sum(weights, activations);
                if (in_last) begin
                    expected = running + beat + bias;
                    expected_q.push_back(expected);
                    last_edge_q.push_back(edge_index);
                    running = '0;
                end else begin
                    running = running + beat;
                end
            end
            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_data  = dot_product;
            pending    = expected_q.size();
        end
    end

endmodule

`default_nettype wire

// ==== tb_mac_array.sv ====
// testbench top with clock, reset, random stimulus, back-pressure, DUT, checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mac_array
    import mac_fixed_pkg::*, mac_geometry_pkg::*;
();

    localparam int NUM_DOTS  = 300;
    localparam int MAX_BEATS = 8;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    array_vec_t weights;
    array_vec_t activations;
    logic       in_last;
    sample_t    bias;
    logic       out_valid;
    logic       out_ready;
    sample_t    dot_product;

    logic backpressure;
    logic small_values;
    int   lengths [NUM_DOTS];
    int   total_beats;
    int   cycle_count = 0;
    int   cycle_limit;
    int   value_errors;
    int   other_errors;
    int   results_seen;
    int   pending;

    always #5 clk = ~clk;

    mac_array i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .weights     (weights),
        .activations (activations),
        .in_last     (in_last),
        .bias        (bias),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .dot_product (dot_product)
    );

    mac_checker i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .weights      (weights),
        .activations  (activations),
        .in_last      (in_last),
        .bias         (bias),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .dot_product  (dot_product),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .results_seen (results_seen),
        .pending      (pending)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // small mode keeps values within +-2.0 in Q8.8
    function automatic sample_t random_sample(input logic narrow);
        if (narrow) begin
            return sample_t'(int'($urandom_range(0, 1023)) - 512);
        end
        return sample_t'($urandom());
    endfunction

    task automatic next_edge();
        @(posedge clk);
        if (backpressure) begin
            out_ready <= 1'($urandom_range(0, 1));
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    // bias drawn on every beat but used only on the last
    task automatic send_beat(input logic last);
        array_vec_t w;
        array_vec_t a;
        for (int i = 0; i < TOTAL_LANES; i++) begin
            w[i] = random_sample(small_values);
            a[i] = random_sample(small_values);
        end
        in_valid    <= 1'b1;
        weights     <= w;
        activations <= a;
        in_last     <= last;
        bias        <= random_sample(small_values);
        next_edge();
        while (!in_ready) begin
            next_edge();
        end
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        repeat (n) next_edge();
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d other, %0d results outstanding, %0d results seen",
                 value_errors, other_errors, pending, results_seen);
    endtask

    //////////////////////////////////////////////////////////////////////
    // timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with %0d of %0d results seen",
                     cycle_count, results_seen, NUM_DOTS);
            report_counts();
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3c6d_e083));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        weights      = '0;
        activations  = '0;
        in_last      = 1'b0;
        bias         = '0;
        out_ready    = 1'b1;
        backpressure = 1'b0;
        small_values = 1'b0;
        total_beats  = 0;
        for (int d = 0; d < NUM_DOTS; d++) begin
            lengths[d]  = int'($urandom_range(1, MAX_BEATS));
            total_beats = total_beats + lengths[d];
        end
        cycle_limit = total_beats * 4 + 1000;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(3);

        // full range, then small values, then back-pressure with both
        for (int d = 0; d < NUM_DOTS; d++) begin
            backpressure = (d >= 200);
            small_values = (d >= 100 && d < 200) || (d >= 200 && d % 2 == 1);
            for (int b = 0; b < lengths[d]; b++) begin
                if ($urandom_range(0, 3) == 0) begin
                    idle_cycles(int'($urandom_range(1, 3)));
                end
                send_beat(b == lengths[d] - 1);
            end
        end
        idle_cycles(1);
        while (results_seen < NUM_DOTS) begin
            next_edge();
        end
        // extra cycles to catch duplicated results
        repeat (20) next_edge();

        report_counts();
        if (value_errors == 0 && other_errors == 0 && pending == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
mac_fixed_pkg.sv
mac_geometry_pkg.sv
mac_pe.sv
mac_channel.sv
dot_accumulator.sv
mac_array.sv
mac_checker.sv
tb_mac_array.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the MAC array testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f \
    --top-module tb_mac_array \
    -Mdir obj_dir \
    -o tb_mac_array

./obj_dir/tb_mac_array | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
